// ==== common/tile_pkg.sv ====
package tile_pkg;

  // Bus widths
  localparam int ADDR_W = 32;  // Word address
  localparam int DATA_W = 32;  // Store data word

  // Magic addresses, never backed by memory
  localparam logic [ADDR_W-1:0] EOC_ADDR    = 32'hFFFF_0000;  // Exit code
  localparam logic [ADDR_W-1:0] STDOUT_ADDR = 32'hFFFF_0004;  // One character

  // Width of the character field in a console word
  localparam int CHAR_W = 8;

  // One store word, seen raw or as a console byte
  typedef union packed {
    logic [DATA_W-1:0] word;  // Plain memory data, exit code
    struct packed {
      logic [DATA_W-CHAR_W-1:0] upper;  // Must be zero for a valid char
      logic [CHAR_W-1:0]        ch;     // Printed character
    } con;
  } store_data_u;

endpackage

// ==== common/wr_if.sv ====
`timescale 1ns/1ps

// Write channel that transfers on valid && !block
interface wr_if import tile_pkg::*; ();

  logic              valid;  // Entry present
  logic [ADDR_W-1:0] addr;   // Target word address
  store_data_u       data;   // Payload
  logic              block;  // Sink cannot take it this cycle

  // Producer side holds its entry while blocked
  modport source (
    output valid,
    output addr,
    output data,
    input  block
  );

  modport sink (
    input  valid,
    input  addr,
    input  data,
    output block
  );

endinterface

// ==== compile.f ====
common/tile_pkg.sv
common/wr_if.sv
store_engine/store_engine.sv
verilog/wr_fifo.sv
l2_sink/l2_sink.sv
verilog/tile_top.sv
sim/tile_tb.sv

// ==== l2_sink/l2_sink.sv ====
`timescale 1ns/1ps

module l2_sink import tile_pkg::*; #(
  parameter int MEM_WORDS = 64
) (
  input  logic              clk,
  input  logic              arst_n_i,
  wr_if.sink                wr,
  input  logic              stall_i,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              eoc_valid_o,
  output logic [DATA_W-1:0] exit_code_o,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0] mem [MEM_WORDS];  // L2 word store

  logic             xfer;
  logic             is_eoc;
  logic             is_con;
  logic             con_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  assign wr.block = stall_i;  // External back-pressure
  assign xfer     = wr.valid & ~wr.block;

  // Address decode
  assign is_eoc = (wr.addr == EOC_ADDR);
  assign is_con = (wr.addr == STDOUT_ADDR);

  // Only 1..255 prints while zero and wide values drop
  assign con_ok = (wr.data.con.ch != '0) && (wr.data.con.upper == '0);

  // Word index wraps at the memory size
  assign wr_idx = IDX_W'(wr.addr % ADDR_W'(MEM_WORDS));
  assign rd_idx = IDX_W'(rd_addr_i % ADDR_W'(MEM_WORDS));

  assign rd_data_o = mem[rd_idx];  // Combinational read port

  // Console and EOC strobes
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      char_valid_o <= 1'b0;
      eoc_valid_o  <= 1'b0;
      exit_code_o  <= '0;
    end else begin
      char_valid_o <= xfer & is_con & con_ok;  // Single-cycle pulse
      eoc_valid_o  <= xfer & is_eoc;
      if (xfer && is_eoc) begin
        exit_code_o <= wr.data.word;  // Held until next exit write
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && is_con) begin
      char_o <= wr.data.con.ch;
    end
    // Magic addresses never reach the array
    if (xfer && !is_eoc && !is_con) begin
      mem[wr_idx] <= wr.data.word;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the tile testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tile_tb -f compile.f -o tile_sim
./obj_dir/tile_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "sim passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== sim/tile_tb.sv ====
`timescale 1ns/1ps

module tile_tb import tile_pkg::*; ();

  localparam int FIFO_DEPTH = 4;
  localparam int MEM_WORDS  = 64;
  localparam int N_JOBS     = 40;
  localparam int MAX_LEN    = 20;
  localparam int WDOG_NS    = N_JOBS * (MAX_LEN + 1 + 4) * 4 * 10;  // Stalls cost up to 4x

  logic              clk;
  logic              arst_n_i;
  logic              start_i;
  logic [ADDR_W-1:0] base_addr_i;
  logic [DATA_W-1:0] first_i;
  logic [DATA_W-1:0] stride_i;
  logic [7:0]        len_i;
  logic              busy_o;
  logic              mem_stall_i;
  logic              char_valid_o;
  logic [7:0]        char_o;
  logic              eoc_valid_o;
  logic [DATA_W-1:0] exit_code_o;
  logic [ADDR_W-1:0] rd_addr_i;
  logic [DATA_W-1:0] rd_data_o;

  logic [DATA_W-1:0] model_mem [MEM_WORDS];  // Expected L2 contents
  logic              model_ok  [MEM_WORDS];  // Word written at least once
  logic [31:0]       rng_q;
  int                burst_q;                // Stall cycles left in a burst

  tile_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .MEM_WORDS  (MEM_WORDS)
  ) tile_top_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .base_addr_i  (base_addr_i),
    .first_i      (first_i),
    .stride_i     (stride_i),
    .len_i        (len_i),
    .busy_o       (busy_o),
    .mem_stall_i  (mem_stall_i),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .eoc_valid_o  (eoc_valid_o),
    .exit_code_o  (exit_code_o),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    #(WDOG_NS);
    $display("Timeout: the jobs did not complete within %0d ns", WDOG_NS);
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw();
    rng_q = xorshift32(rng_q);
    return rng_q;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Mode 0 quiet, 3 long bursts, others about 30 % random
  task automatic drive_stall(input int mode);
    logic [31:0] r;
    r = draw();
    if (mode == 0) begin
      mem_stall_i <= 1'b0;
    end else if (mode == 3) begin
      if (burst_q > 0) begin
        burst_q = burst_q - 1;
        mem_stall_i <= 1'b1;
      end else if (r % 32'd20 == 32'd0) begin
        burst_q = 7 + int'(r[6:4]);  // 8 to 15 cycles outlast the FIFO
        mem_stall_i <= 1'b1;
      end else begin
        mem_stall_i <= 1'b0;
      end
    end else begin
      mem_stall_i <= (r % 32'd10) < 32'd3;
    end
  endtask

  task automatic check_word(input int idx);
    logic [31:0] alias_k;
    alias_k = draw() % 32'd4;
    @(posedge clk);
    rd_addr_i <= ADDR_W'(idx) + ADDR_W'(MEM_WORDS) * alias_k;  // Aliases hit same word
    @(negedge clk);
    if (model_ok[idx]) check_eq($sformatf("rd_data_o word %0d", idx), model_mem[idx], rd_data_o);
  endtask

  task automatic run_job(input int j);
    logic [ADDR_W-1:0] base;
    logic [DATA_W-1:0] first;
    logic [DATA_W-1:0] stride;
    logic [DATA_W-1:0] val;
    logic [DATA_W-1:0] sum;
    logic [31:0]       off;
    logic [31:0]       alias_k;
    logic [7:0]        len;
    logic [7:0]        exp_ch;
    int                mode;
    int                cyc;
    int                n_char;
    first  = draw();
    stride = draw();
    if (j % 5 == 4) begin
      len     = 8'(32'd12 + draw() % 32'd9);  // Long enough to cross word 0
      off     = draw() % 32'd8;
      alias_k = draw() % 32'd3;
      base    = ADDR_W'(MEM_WORDS - 8) + off + ADDR_W'(MEM_WORDS) * alias_k;
    end else begin
      len  = 8'(draw() % 32'd21);
      base = draw() % ADDR_W'(MEM_WORDS);
    end
    if (j == 2) len = 8'd0;  // Empty job prints nothing
    mode = int'(draw() % 32'd4);
    if (j == 0) mode = 0;
    if (j == 1) mode = 3;
    // Reference model puts element k at base + k with value first + k * stride
    val = first;
    sum = '0;
    for (int k = 0; k < int'(len); k++) begin
      model_mem[int'((base + ADDR_W'(k)) % ADDR_W'(MEM_WORDS))] = val;
      model_ok[int'((base + ADDR_W'(k)) % ADDR_W'(MEM_WORDS))]  = 1'b1;
      sum = sum + val;
      val = val + stride;
    end
    exp_ch  = sum[7:0];
    burst_q = 0;
    @(posedge clk);
    start_i     <= 1'b1;
    base_addr_i <= base;
    first_i     <= first;
    stride_i    <= stride;
    len_i       <= len;
    drive_stall(mode);
    @(posedge clk);  // Start sampled here
    start_i <= 1'b0;
    drive_stall(mode);
    cyc    = 1;
    n_char = 0;
    @(negedge clk);
    check_eq("busy_o", 32'd1, 32'(busy_o));
    while (eoc_valid_o !== 1'b1) begin
      @(posedge clk);
      drive_stall(mode);
      cyc++;
      @(negedge clk);
      if (char_valid_o === 1'b1) begin
        n_char++;
        check_eq("char_o", 32'(exp_ch), 32'(char_o));
      end
    end
    check_eq("exit_code_o", 32'(len), exit_code_o);
    check_eq("busy_o", 32'd0, 32'(busy_o));  // Engine done before the sink sees EOC
    check_eq("char_valid_o pulses", (exp_ch != 8'd0) ? 32'd1 : 32'd0, 32'(n_char));
    if (mode == 0) begin
      assert (cyc >= int'(len) + 4) else begin
        $display("Error: job %0d reached eoc_valid_o after %0d cycles, under len + 4", j, cyc);
        $display("sim failed");
        $fatal(1, "latency too short");
      end
    end
    @(posedge clk);
    mem_stall_i <= 1'b0;
    @(negedge clk);
    check_eq("eoc_valid_o", 32'd0, 32'(eoc_valid_o));  // One-cycle pulse
    check_eq("char_valid_o", 32'd0, 32'(char_valid_o));
    // Covered words plus one neighbour on each side
    for (int k = -1; k <= int'(len); k++) begin
      check_word((int'(base % ADDR_W'(MEM_WORDS)) + k + MEM_WORDS) % MEM_WORDS);
    end
  endtask

  initial begin
    rng_q       = 32'h2984_a0d7;
    burst_q     = 0;
    arst_n_i    = 1'b0;
    start_i     = 1'b0;
    base_addr_i = '0;
    first_i     = '0;
    stride_i    = '0;
    len_i       = '0;
    mem_stall_i = 1'b0;
    rd_addr_i   = '0;
    for (int i = 0; i < MEM_WORDS; i++) model_ok[i] = 1'b0;  // L2 has no reset
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_eq("busy_o", 32'd0, 32'(busy_o));
    check_eq("char_valid_o", 32'd0, 32'(char_valid_o));
    check_eq("eoc_valid_o", 32'd0, 32'(eoc_valid_o));
    check_eq("exit_code_o", 32'd0, exit_code_o);
    for (int j = 0; j < N_JOBS; j++) run_job(j);
    for (int i = 0; i < MEM_WORDS; i++) check_word(i);  // Final sweep of the whole store
    $display("sim passed");
    $finish;
  end

endmodule

// ==== store_engine/store_engine.sv ====
`timescale 1ns/1ps

module store_engine import tile_pkg::*; (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [DATA_W-1:0] first_i,
  input  logic [DATA_W-1:0] stride_i,
  input  logic [7:0]        len_i,
  output logic              busy_o,
  wr_if.source              wr
);

  // Sequencer phases
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;  // One write per element
  localparam logic [1:0] ST_CON  = 2'd2;  // Sum byte to console
  localparam logic [1:0] ST_EXIT = 2'd3;  // Length to EOC

  logic [1:0]        state_q;
  logic [7:0]        cnt_q;    // Elements already written
  logic [ADDR_W-1:0] addr_q;   // Address of current element
  logic [DATA_W-1:0] val_q;    // Value of current element
  logic [DATA_W-1:0] stride_q;
  logic [7:0]        len_q;
  logic [DATA_W-1:0] sum_q;    // Wraps at 32 bits

  logic        start;
  logic        xfer;
  logic        last_elem;
  store_data_u wdata;

  assign start     = start_i & ~busy_o;  // Ignored while a job runs
  assign xfer      = wr.valid & ~wr.block;
  assign last_elem = (cnt_q == len_q - 8'd1);

  assign busy_o = (state_q != ST_IDLE);

  // Present an entry in every active phase
  assign wr.valid = busy_o;
  assign wr.data  = wdata;

  always_comb begin
    wdata = '0;
    case (state_q)
      ST_CON: begin
        wr.addr         = STDOUT_ADDR;
        wdata.con.upper = '0;
        wdata.con.ch    = sum_q[CHAR_W-1:0];  // Low byte of the sum
      end
      ST_EXIT: begin
        wr.addr    = EOC_ADDR;
        wdata.word = DATA_W'(len_q);  // Exit code is the job length
      end
      default: begin
        wr.addr    = addr_q;
        wdata.word = val_q;
      end
    endcase
  end

  // Phase and element count
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            cnt_q   <= '0;
            state_q <= (len_i == 8'd0) ? ST_CON : ST_DATA;  // Empty job skips data
          end
        end
        ST_DATA: begin
          if (xfer) begin
            cnt_q <= cnt_q + 8'd1;
            if (last_elem) state_q <= ST_CON;
          end
        end
        ST_CON: begin
          if (xfer) state_q <= ST_EXIT;
        end
        default: begin
          if (xfer) state_q <= ST_IDLE;  // busy_o drops on the exit transfer
        end
      endcase
    end
  end

  // Job datapath loaded on start
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q   <= base_addr_i;
      val_q    <= first_i;
      stride_q <= stride_i;
      len_q    <= len_i;
      sum_q    <= '0;
    end else if (xfer && state_q == ST_DATA) begin
      addr_q <= addr_q + ADDR_W'(1);  // Next word
      val_q  <= val_q + stride_q;
      sum_q  <= sum_q + val_q;        // Accumulate value just written
    end
  end

endmodule

// ==== verilog/tile_top.sv ====
`timescale 1ns/1ps

module tile_top import tile_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_WORDS  = 64
) (
  input  logic              clk,
  input  logic              arst_n_i,
  // Job request
  input  logic              start_i,
  input  logic [ADDR_W-1:0] base_addr_i,
  input  logic [DATA_W-1:0] first_i,
  input  logic [DATA_W-1:0] stride_i,
  input  logic [7:0]        len_i,
  output logic              busy_o,
  // L2 side
  input  logic              mem_stall_i,
  output logic              char_valid_o,
  output logic [7:0]        char_o,
  output logic              eoc_valid_o,
  output logic [DATA_W-1:0] exit_code_o,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic [DATA_W-1:0] rd_data_o
);

  wr_if eng_wr ();  // Engine to FIFO
  wr_if mem_wr ();  // FIFO to L2

  store_engine store_engine_i (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .start_i     (start_i),
    .base_addr_i (base_addr_i),
    .first_i     (first_i),
    .stride_i    (stride_i),
    .len_i       (len_i),
    .busy_o      (busy_o),
    .wr          (eng_wr.source)
  );

  wr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) wr_fifo_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .in       (eng_wr.sink),
    .out      (mem_wr.source)
  );

  l2_sink #(
    .MEM_WORDS (MEM_WORDS)
  ) l2_sink_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wr           (mem_wr.sink),
    .stall_i      (mem_stall_i),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .eoc_valid_o  (eoc_valid_o),
    .exit_code_o  (exit_code_o),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o)
  );

endmodule

// ==== verilog/wr_fifo.sv ====
`timescale 1ns/1ps

module wr_fifo import tile_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic clk,
  input  logic arst_n_i,
  wr_if.sink   in,
  wr_if.source out
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Entry storage
  logic [ADDR_W-1:0] addr_mem [FIFO_DEPTH];
  store_data_u       data_mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  logic full;
  logic push;
  logic pop;

  assign full = (cnt_q == CNT_W'(FIFO_DEPTH));

  // Full blocks unless the head leaves in the same cycle
  assign in.block = full & out.block;

  assign out.valid = (cnt_q != '0);  // Non-empty level
  assign out.addr  = addr_mem[rd_ptr_q];
  assign out.data  = data_mem[rd_ptr_q];

  assign push = in.valid & ~in.block;
  assign pop  = out.valid & ~out.block;

  // Circular increment for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    ptr_next = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      // Count only moves on a lone push or pop
      if (push && !pop) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= in.addr;
      data_mem[wr_ptr_q] <= in.data;  // Head slot may be refilled as it pops
    end
  end

endmodule
